// ==== common/soc_pkg.sv ====
// Memory fabric shared definitions
package soc_pkg;

    // ----------------------------------------
    // Bus types
    // ----------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  be_t;
    typedef logic [7:0]  led_t;

    // Decode targets, TGT_NONE marks an unmapped address
    typedef enum logic [2:0] {
        TGT_ROM   = 3'd0,
        TGT_CLINT = 3'd1,
        TGT_GPIO  = 3'd2,
        TGT_RAM   = 3'd3,
        TGT_NONE  = 3'd7
    } target_e;

    // ----------------------------------------
    // Memory map
    // ----------------------------------------
    localparam addr_t ROM_BASE     = 32'h0001_0000;
    localparam addr_t ROM_LENGTH   = 32'h0000_0040;
    localparam addr_t CLINT_BASE   = 32'h0200_0000;
    localparam addr_t CLINT_LENGTH = 32'h0000_C000;
    localparam addr_t GPIO_BASE    = 32'h4000_0000;
    localparam addr_t GPIO_LENGTH  = 32'h0000_1000;
    // RAM length follows the RamWords parameter
    localparam addr_t RAM_BASE     = 32'h8000_0000;

    // Register offsets inside their regions
    localparam addr_t MTIMECMP_OFFSET = 32'h0000_4000;
    localparam addr_t MTIME_OFFSET    = 32'h0000_BFF8;
    localparam addr_t LED_OFFSET      = 32'h0000_0000;
    localparam addr_t SW_OFFSET       = 32'h0000_0008;

    // Boot image, two instructions per word
    localparam data_t BOOT_IMAGE [8] = '{
        64'h0202_8293_0000_0297,
        64'h0002_8067_0182_B283,
        64'h3040_1073_0000_0013,
        64'h1050_0073_0080_0093,
        64'hFFDF_F06F_0010_8093,
        64'h0000_0000_8000_0000,
        64'hDEAD_BEEF_CAFE_F00D,
        64'h0123_4567_89AB_CDEF
    };

endpackage

// ==== common/mem_bus_if.sv ====
// Single-beat memory bus
`timescale 1ns/1ps

interface mem_bus_if import soc_pkg::*; ();

    logic  req;
    logic  we;
    addr_t addr;    // offset inside the target region
    data_t wdata;
    be_t   be;
    data_t rdata;   // registered by the target, one cycle after req

    modport ctrl (
        output req,
        output we,
        output addr,
        output wdata,
        output be,
        input  rdata
    );

    modport target (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  be,
        output rdata
    );

endinterface

// ==== verilog/bus_demux.sv ====
// Address decoder and read mux
`timescale 1ns/1ps

module bus_demux import soc_pkg::*; #(
    parameter int unsigned RamWords = 512
) (
    input  logic  clk,
    input  logic  ndmreset_n,
    input  logic  req_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  data_t wdata_i,
    input  be_t   be_i,
    mem_bus_if.ctrl rom_o,
    mem_bus_if.ctrl clint_o,
    mem_bus_if.ctrl gpio_o,
    mem_bus_if.ctrl ram_o,
    output data_t rdata_o,
    output logic  rvalid_o,
    output logic  err_o
);

    localparam addr_t RamBytes = addr_t'(RamWords * 8);

    target_e sel;
    target_e sel_q;
    logic    in_rom;
    logic    in_clint;
    logic    in_gpio;
    logic    in_ram;
    logic    rvalid_q;
    logic    err_q;

    // Region match with base compare first so the subtraction cannot wrap
    assign in_rom   = (addr_i >= ROM_BASE) && ((addr_i - ROM_BASE) < ROM_LENGTH);
    assign in_clint = (addr_i >= CLINT_BASE) && ((addr_i - CLINT_BASE) < CLINT_LENGTH);
    assign in_gpio  = (addr_i >= GPIO_BASE) && ((addr_i - GPIO_BASE) < GPIO_LENGTH);
    assign in_ram   = (addr_i >= RAM_BASE) && ((addr_i - RAM_BASE) < RamBytes);

    always_comb begin
        if (in_rom) begin
            sel = TGT_ROM;
        end else if (in_clint) begin
            sel = TGT_CLINT;
        end else if (in_gpio) begin
            sel = TGT_GPIO;
        end else if (in_ram) begin
            sel = TGT_RAM;
        end else begin
            sel = TGT_NONE;
        end
    end

    // Each strobe follows its own region match
    assign rom_o.req     = req_i && in_rom;
    assign rom_o.we      = we_i;
    assign rom_o.addr    = addr_i - ROM_BASE;
    assign rom_o.wdata   = wdata_i;
    assign rom_o.be      = be_i;

    assign clint_o.req   = req_i && in_clint;
    assign clint_o.we    = we_i;
    assign clint_o.addr  = addr_i - CLINT_BASE;
    assign clint_o.wdata = wdata_i;
    assign clint_o.be    = be_i;

    assign gpio_o.req    = req_i && in_gpio;
    assign gpio_o.we     = we_i;
    assign gpio_o.addr   = addr_i - GPIO_BASE;
    assign gpio_o.wdata  = wdata_i;
    assign gpio_o.be     = be_i;

    assign ram_o.req     = req_i && in_ram;
    assign ram_o.we      = we_i;
    assign ram_o.addr    = addr_i - RAM_BASE;
    assign ram_o.wdata   = wdata_i;
    assign ram_o.be      = be_i;

    // ----------------------------------------
    // Response cycle
    // ----------------------------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            sel_q    <= TGT_NONE;
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            rvalid_q <= req_i && !we_i;
            err_q    <= req_i && (sel == TGT_NONE);
            if (req_i) begin
                sel_q <= sel;
            end
        end
    end

    always_comb begin
        case (sel_q)
            TGT_ROM:   rdata_o = rom_o.rdata;
            TGT_CLINT: rdata_o = clint_o.rdata;
            TGT_GPIO:  rdata_o = gpio_o.rdata;
            TGT_RAM:   rdata_o = ram_o.rdata;
            default:   rdata_o = '0;
        endcase
    end

    assign rvalid_o = rvalid_q;
    assign err_o    = err_q;

    // Regions must never overlap
    a_one_target: assert property (@(posedge clk) disable iff (!ndmreset_n)
        $onehot0({rom_o.req, clint_o.req, gpio_o.req, ram_o.req}));

endmodule

// ==== verilog/gpio_regs.sv ====
// LED and switch registers
`timescale 1ns/1ps

module gpio_regs import soc_pkg::*; (
    input  logic ndmreset_n,
    input  logic clk,
    mem_bus_if.target bus_i,
    output led_t led_o,
    input  led_t sw_i
);

    led_t led_q;
    led_t sw_meta_q;
    led_t sw_sync_q;

    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            led_q     <= '0;
            sw_meta_q <= '0;
            sw_sync_q <= '0;
        end else begin
            // Two-flop synchronizer for the switches
            sw_meta_q <= sw_i;
            sw_sync_q <= sw_meta_q;
            if (bus_i.req && bus_i.we && bus_i.addr == LED_OFFSET && bus_i.be[0]) begin
                led_q <= bus_i.wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_i.req && !bus_i.we) begin
            case (bus_i.addr)
                LED_OFFSET: bus_i.rdata <= {56'h0, led_q};
                SW_OFFSET:  bus_i.rdata <= {56'h0, sw_sync_q};
                default:    bus_i.rdata <= '0;
            endcase
        end
    end

    assign led_o = led_q;

endmodule

// ==== clint/clint_timer.sv ====
// Core-local timer
`timescale 1ns/1ps

module clint_timer import soc_pkg::*; (
    input  logic clk,
    input  logic ndmreset_n,
    mem_bus_if.target bus_i,
    output logic timer_irq_o
);

    logic  rtc_q;
    data_t mtime_q;
    data_t mtimecmp_q;
    logic  wr_mtime;
    logic  wr_mtimecmp;

    // Replace only the enabled bytes of a register
    function automatic data_t merge_bytes(data_t old_v, data_t new_v, be_t be);
        data_t res;
        res = old_v;
        for (int i = 0; i < 8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wr_mtime    = bus_i.req && bus_i.we && (bus_i.addr == MTIME_OFFSET);
    assign wr_mtimecmp = bus_i.req && bus_i.we && (bus_i.addr == MTIMECMP_OFFSET);

    // ----------------------------------------
    // RTC tick and counters
    // ----------------------------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rtc_q      <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            rtc_q <= ~rtc_q;
            // Bus write wins over the count
            if (wr_mtime) begin
                mtime_q <= merge_bytes(mtime_q, bus_i.wdata, bus_i.be);
            end else if (!rtc_q) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr_mtimecmp) begin
                mtimecmp_q <= merge_bytes(mtimecmp_q, bus_i.wdata, bus_i.be);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_i.req && !bus_i.we) begin
            case (bus_i.addr)
                MTIME_OFFSET:    bus_i.rdata <= mtime_q;
                MTIMECMP_OFFSET: bus_i.rdata <= mtimecmp_q;
                default:         bus_i.rdata <= '0;
            endcase
        end
    end

    assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

// ==== rom/boot_rom.sv ====
// Boot ROM
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
    input  logic clk,
    mem_bus_if.target bus_i
);

    logic [2:0] word_idx;

    // Eight words, byte offset bits dropped
    assign word_idx = bus_i.addr[5:3];

    // Writes never touch the image
    always_ff @(posedge clk) begin
        if (bus_i.req && !bus_i.we) begin
            bus_i.rdata <= BOOT_IMAGE[word_idx];
        end
    end

endmodule

// ==== bram/sram_bank.sv ====
// Single-port RAM with byte enables
`timescale 1ns/1ps

module sram_bank import soc_pkg::*; #(
    parameter int unsigned RamWords = 512
) (
    input  logic clk,
    mem_bus_if.target bus_i
);

    localparam int unsigned IdxW = $clog2(RamWords);

    data_t           mem [RamWords];
    logic [IdxW-1:0] word_idx;

    assign word_idx = bus_i.addr[IdxW+2:3];

    always_ff @(posedge clk) begin
        if (bus_i.req) begin
            if (bus_i.we) begin
                for (int i = 0; i < 8; i++) begin
                    if (bus_i.be[i]) begin
                        mem[word_idx][8*i +: 8] <= bus_i.wdata[8*i +: 8];
                    end
                end
            end else begin
                bus_i.rdata <= mem[word_idx];
            end
        end
    end

    // Decoder must keep requests inside the array
    a_idx_range: assert property (@(posedge clk)
        bus_i.req |-> (bus_i.addr[31:3] < RamWords));

endmodule

// ==== verilog/soc_top.sv ====
// Memory fabric top level
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
    parameter int unsigned RamWords = 512
) (
    input  logic  clk,
    input  logic  ndmreset_n,
    input  logic  req_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  data_t wdata_i,
    input  be_t   be_i,
    output data_t rdata_o,
    output logic  rvalid_o,
    output logic  err_o,
    output logic  timer_irq_o,
    output led_t  led_o,
    input  led_t  sw_i
);

    mem_bus_if rom_bus ();
    mem_bus_if clint_bus ();
    mem_bus_if gpio_bus ();
    mem_bus_if ram_bus ();

    // ----------------------------------------
    // Decoder
    // ----------------------------------------
    bus_demux #(.RamWords(RamWords)) i_bus_demux (
        .clk        (clk),
        .ndmreset_n (ndmreset_n),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .be_i       (be_i),
        .rom_o      (rom_bus),
        .clint_o    (clint_bus),
        .gpio_o     (gpio_bus),
        .ram_o      (ram_bus),
        .rdata_o    (rdata_o),
        .rvalid_o   (rvalid_o),
        .err_o      (err_o)
    );

    // ----------------------------------------
    // Targets
    // ----------------------------------------
    boot_rom i_boot_rom (
        .clk   (clk),
        .bus_i (rom_bus)
    );

    sram_bank #(.RamWords(RamWords)) i_sram_bank (
        .clk   (clk),
        .bus_i (ram_bus)
    );

    clint_timer i_clint_timer (
        .clk         (clk),
        .ndmreset_n  (ndmreset_n),
        .bus_i       (clint_bus),
        .timer_irq_o (timer_irq_o)
    );

    gpio_regs i_gpio_regs (
        .clk        (clk),
        .ndmreset_n (ndmreset_n),
        .bus_i      (gpio_bus),
        .led_o      (led_o),
        .sw_i       (sw_i)
    );

endmodule

// ==== test/tb_soc.sv ====
// Memory fabric testbench
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

    localparam int unsigned RamWords     = 512;
    localparam int unsigned WaitLimit    = 16;
    localparam int unsigned IrqWaitLimit = 200;
    localparam addr_t       UnmappedAddr = 32'h2000_0000;

    logic  clk;
    logic  ndmreset_n;
    logic  req_i;
    logic  we_i;
    addr_t addr_i;
    data_t wdata_i;
    be_t   be_i;
    data_t rdata_o;
    logic  rvalid_o;
    logic  err_o;
    logic  timer_irq_o;
    led_t  led_o;
    led_t  sw_i;

    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    string cur_test;

    soc_top #(.RamWords(RamWords)) dut_i (
        .clk         (clk),
        .ndmreset_n  (ndmreset_n),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .be_i        (be_i),
        .rdata_o     (rdata_o),
        .rvalid_o    (rvalid_o),
        .err_o       (err_o),
        .timer_irq_o (timer_irq_o),
        .led_o       (led_o),
        .sw_i        (sw_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_data(input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_led(input led_t exp, input led_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %b, actual %b", cur_test, exp, act);
            errors++;
        end
    endtask

    // Expected word after a write with byte enables
    function automatic data_t apply_enables(data_t old_w, data_t new_w, be_t b);
        data_t mask;
        mask = '0;
        for (int i = 0; i < 8; i++) begin
            mask[8*i +: 8] = {8{b[i]}};
        end
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            $display("%s: pass", cur_test);
        end else begin
            $display("%s: fail with %0d errors", cur_test, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    // ----------------------------------------
    // Bus tasks
    // ----------------------------------------
    // Returns on the falling edge right after the strobe edge
    task automatic bus_write(input addr_t a, input data_t d, input be_t b);
        @(negedge clk);
        req_i   = 1'b1;
        we_i    = 1'b1;
        addr_i  = a;
        wdata_i = d;
        be_i    = b;
        @(negedge clk);
        req_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic bus_read(input addr_t a, output data_t d, output logic e);
        int waited;
        @(negedge clk);
        req_i  = 1'b1;
        we_i   = 1'b0;
        addr_i = a;
        be_i   = '1;
        @(negedge clk);
        req_i  = 1'b0;
        waited = 0;
        while (!rvalid_o && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!rvalid_o) begin
            $display("Timeout in %s: no read response from address %h", cur_test, a);
            errors++;
            d = '0;
            e = 1'b0;
        end else begin
            d = rdata_o;
            e = err_o;
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic reset_state_test();
        start_test("reset_state");
        check_flag(1'b0, rvalid_o);
        check_flag(1'b0, err_o);
        check_flag(1'b0, timer_irq_o);
        check_led('0, led_o);
        finish_test();
    endtask

    task automatic rom_read_test();
        data_t rd;
        logic  e;
        start_test("rom_read");
        for (int i = 0; i < 8; i++) begin
            bus_read(ROM_BASE + addr_t'(8 * i), rd, e);
            check_data(BOOT_IMAGE[i], rd);
        end
        bus_write(ROM_BASE + 32'h8, {$urandom, $urandom}, '1);
        bus_read(ROM_BASE + 32'h8, rd, e);
        check_data(BOOT_IMAGE[1], rd);
        finish_test();
    endtask

    task automatic ram_byte_enable_test();
        data_t       model [int];
        int unsigned idx [8];
        data_t       wd;
        data_t       rd;
        be_t         b;
        logic        e;
        start_test("ram_byte_enable");
        for (int k = 0; k < 8; k++) begin
            idx[k] = $urandom_range(RamWords - 1, 0);
            wd     = {$urandom, $urandom};
            bus_write(RAM_BASE + addr_t'(idx[k] * 8), wd, 8'hFF);
            model[idx[k]] = wd;
        end
        for (int k = 0; k < 8; k++) begin
            wd = {$urandom, $urandom};
            b  = be_t'($urandom);
            bus_write(RAM_BASE + addr_t'(idx[k] * 8), wd, b);
            model[idx[k]] = apply_enables(model[idx[k]], wd, b);
        end
        for (int k = 0; k < 8; k++) begin
            bus_read(RAM_BASE + addr_t'(idx[k] * 8), rd, e);
            check_data(model[idx[k]], rd);
        end
        finish_test();
    endtask

    task automatic unmapped_test();
        data_t rd;
        logic  e;
        start_test("unmapped");
        bus_read(UnmappedAddr, rd, e);
        check_flag(1'b1, e);
        check_data('0, rd);
        bus_write(UnmappedAddr, {$urandom, $urandom}, '1);
        check_flag(1'b1, err_o);
        check_flag(1'b0, rvalid_o);
        bus_read(ROM_BASE, rd, e);
        check_flag(1'b0, e);
        check_data(BOOT_IMAGE[0], rd);
        finish_test();
    endtask

    task automatic timer_count_test();
        data_t t0;
        data_t t1;
        logic  e;
        start_test("timer_count");
        check_flag(1'b0, timer_irq_o);
        bus_read(CLINT_BASE + MTIME_OFFSET, t0, e);
        // Second strobe lands exactly 20 clocks after the first
        repeat (18) @(negedge clk);
        bus_read(CLINT_BASE + MTIME_OFFSET, t1, e);
        check_data(64'd10, t1 - t0);
        finish_test();
    endtask

    task automatic timer_compare_test();
        data_t t;
        logic  e;
        int    waited;
        start_test("timer_compare");
        bus_write(CLINT_BASE + MTIME_OFFSET, 64'd0, '1);
        bus_write(CLINT_BASE + MTIMECMP_OFFSET, 64'd40, '1);
        check_flag(1'b0, timer_irq_o);
        waited = 0;
        while (!timer_irq_o && waited < IrqWaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!timer_irq_o) begin
            $display("Timeout in %s: the timer interrupt never went high", cur_test);
            errors++;
        end
        bus_read(CLINT_BASE + MTIME_OFFSET, t, e);
        check_flag(1'b1, t >= 64'd40);
        bus_write(CLINT_BASE + MTIMECMP_OFFSET, '1, '1);
        check_flag(1'b0, timer_irq_o);
        finish_test();
    endtask

    task automatic gpio_test();
        led_t  led_val;
        led_t  sw_val;
        data_t rd;
        logic  e;
        start_test("gpio");
        // Nonzero so the value differs from the reset state
        led_val = led_t'($urandom_range(255, 1));
        bus_write(GPIO_BASE + LED_OFFSET, {56'h0, led_val}, 8'h01);
        check_led(led_val, led_o);
        bus_read(GPIO_BASE + LED_OFFSET, rd, e);
        check_data({56'h0, led_val}, rd);
        @(negedge clk);
        sw_val = led_t'($urandom_range(255, 1));
        sw_i   = sw_val;
        // Switches pass two synchronizer flops
        repeat (3) @(negedge clk);
        bus_read(GPIO_BASE + SW_OFFSET, rd, e);
        check_data({56'h0, sw_val}, rd);
        finish_test();
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h21a0_d3c3));
        ndmreset_n = 1'b0;
        req_i      = 1'b0;
        we_i       = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        be_i       = '0;
        sw_i       = '0;
        repeat (3) @(negedge clk);
        ndmreset_n = 1'b1;

        reset_state_test();
        rom_read_test();
        ram_byte_enable_test();
        unmapped_test();
        timer_count_test();
        timer_compare_test();
        gpio_test();

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== soc.f ====
common/soc_pkg.sv
common/mem_bus_if.sv
verilog/bus_demux.sv
verilog/gpio_regs.sv
clint/clint_timer.sv
rom/boot_rom.sv
bram/sram_bank.sv
verilog/soc_top.sv
test/tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_soc \
    --Mdir obj_dir \
    -o tb_soc_sim \
    -f soc.f

./obj_dir/tb_soc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
